// ==== include/soc_defs.svh ====
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// Bus widths
`define SOC_DATA_W 32
`define SOC_ADDR_W 30

// Address map in words, devices packed from zero
`define SOC_DEVTBL_BASE 0
`define SOC_DEVTBL_WORDS 16
`define SOC_INTCTRL_BASE 16
`define SOC_INTCTRL_WORDS 4

// Device table, invalid device last
`define SOC_SLAVE_COUNT 3

// Ids reported through the device table
`define SOC_ID_DEVTBL 7
`define SOC_ID_INTCTRL 3
`define SOC_ID_INVALID 0
`define SOC_SOC_ID 5

// Cycles of system reset after the button or a software request
`define SOC_RST_CYCLES 16

// Interrupt sources on the single destination
`define SOC_IRQ_SRC_COUNT 2

`endif

// ==== hw/soc_pkg.sv ====
`include "soc_defs.svh"

package soc_pkg;

	typedef logic [`SOC_DATA_W-1:0] data_t;

	// Word address, byte offset bits are not carried
	typedef logic [`SOC_ADDR_W-1:0] addr_t;

	typedef logic [`SOC_IRQ_SRC_COUNT-1:0] irq_vec_t;

	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,
		OP_WRITE = 2'd1,
		OP_READ  = 2'd2
	} bus_op_t;

	typedef enum logic [1:0] {
		SEL_DEVTBL,
		SEL_INTCTRL,
		SEL_INVALID
	} slave_sel_t;

	// Encoding of bits 1:0 of the device table control word
	typedef enum logic [1:0] {
		RST_REQ_NONE     = 2'd0,
		RST_REQ_POWEROFF = 2'd1,
		RST_REQ_WARM     = 2'd2,
		RST_REQ_COLD     = 2'd3
	} rst_req_t;

endpackage

// ==== hw/reset_seq.sv ====
`timescale 1ns/1ps
`include "soc_defs.svh"

module reset_seq
	import soc_pkg::*;
(
	input  logic     clk48mhz,
	input  logic     rst_p,
	input  rst_req_t rst_req_i,
	output logic     sys_rst_o
);

	localparam int CNT_W = $clog2(`SOC_RST_CYCLES + 1);

	logic [CNT_W-1:0] cnt_q;
	logic             pwroff_q;
	logic             reload;

	// Cold request takes the same path as warm, there is no global reset
	assign reload = rst_p ||
		(rst_req_i == RST_REQ_WARM) ||
		(rst_req_i == RST_REQ_COLD);

	// Counts down to zero once the reload source goes away
	always_ff @(posedge clk48mhz) begin
		if (reload) begin
			cnt_q <= CNT_W'(`SOC_RST_CYCLES);
		end else if (cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// Power-off stays latched until the button
	always_ff @(posedge clk48mhz) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (rst_req_i == RST_REQ_POWEROFF) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = (cnt_q != '0) || pwroff_q;

endmodule

// ==== hw/bus_decoder.sv ====
`timescale 1ns/1ps
`include "soc_defs.svh"

module bus_decoder
	import soc_pkg::*;
(
	input  logic    clk48mhz,
	input  logic    sys_rst_i,
	input  bus_op_t bus_op_i,
	input  addr_t   bus_addr_i,
	input  data_t   bus_wdata_i,
	output data_t   bus_rdata_o,
	output logic    bus_rdy_o,
	output logic    devtbl_stb_o,
	output logic    intctrl_stb_o,
	output logic    slv_we_o,
	output addr_t   slv_offset_o,
	output data_t   slv_wdata_o,
	input  data_t   devtbl_rdata_i,
	input  data_t   intctrl_rdata_i
);

	slave_sel_t sel;
	addr_t      offset;
	logic       accept;
	data_t      rdata_mux;

	// One request in flight, so nothing new is taken in the ready cycle
	assign accept = (bus_op_i != OP_NONE) && !bus_rdy_o && !sys_rst_i;

	// Region decode; anything outside the two maps goes to the invalid device
	always_comb begin
		sel    = SEL_INVALID;
		offset = '0;
		if ((bus_addr_i >= addr_t'(`SOC_DEVTBL_BASE)) &&
			(bus_addr_i < addr_t'(`SOC_DEVTBL_BASE + `SOC_DEVTBL_WORDS))) begin
			sel    = SEL_DEVTBL;
			offset = bus_addr_i - addr_t'(`SOC_DEVTBL_BASE);
		end else if ((bus_addr_i >= addr_t'(`SOC_INTCTRL_BASE)) &&
			(bus_addr_i < addr_t'(`SOC_INTCTRL_BASE + `SOC_INTCTRL_WORDS))) begin
			sel    = SEL_INTCTRL;
			offset = bus_addr_i - addr_t'(`SOC_INTCTRL_BASE);
		end
	end

	assign devtbl_stb_o  = accept && (sel == SEL_DEVTBL);
	assign intctrl_stb_o = accept && (sel == SEL_INTCTRL);
	assign slv_we_o      = (bus_op_i == OP_WRITE);
	assign slv_offset_o  = offset;
	assign slv_wdata_o   = bus_wdata_i;

	// Invalid device reads as zero
	always_comb begin
		unique case (sel)
			SEL_DEVTBL:  rdata_mux = devtbl_rdata_i;
			SEL_INTCTRL: rdata_mux = intctrl_rdata_i;
			default:     rdata_mux = '0;
		endcase
	end

	always_ff @(posedge clk48mhz) begin
		if (sys_rst_i) begin
			bus_rdy_o <= 1'b0;
		end else begin
			bus_rdy_o <= accept;
		end
	end

	// Captured on the accepting edge, valid with the ready pulse
	always_ff @(posedge clk48mhz) begin
		if (accept) begin
			bus_rdata_o <= (bus_op_i == OP_READ) ? rdata_mux : '0;
		end
	end

endmodule

// ==== hw/dev_table.sv ====
`timescale 1ns/1ps
`include "soc_defs.svh"

module dev_table
	import soc_pkg::*;
(
	input  logic     clk48mhz,
	input  logic     sys_rst_i,
	input  logic     stb_i,
	input  logic     we_i,
	input  addr_t    offset_i,
	input  data_t    wdata_i,
	output data_t    rdata_o,
	output rst_req_t rst_req_o
);

	// Per slave, in decoder order
	localparam int ENT_ID [`SOC_SLAVE_COUNT] = '{
		`SOC_ID_DEVTBL, `SOC_ID_INTCTRL, `SOC_ID_INVALID
	};
	// Map sizes in bytes, invalid device has no map of its own
	localparam int ENT_MAPSZ [`SOC_SLAVE_COUNT] = '{
		`SOC_DEVTBL_WORDS * 4, `SOC_INTCTRL_WORDS * 4, 0
	};
	localparam logic [`SOC_SLAVE_COUNT-1:0] ENT_USEINTR = '0;

	localparam addr_t SOCID_WORD = addr_t'(`SOC_DEVTBL_WORDS - 2);
	localparam addr_t CTRL_WORD  = addr_t'(`SOC_DEVTBL_WORDS - 1);

	logic ctrl_wr;

	assign ctrl_wr = stb_i && we_i && (offset_i == CTRL_WORD);

	// Two words per entry, then the SoC id; the control word reads as zero
	always_comb begin
		rdata_o = '0;
		for (int i = 0; i < `SOC_SLAVE_COUNT; i++) begin
			if (offset_i == addr_t'(2 * i)) begin
				rdata_o[31]   = ENT_USEINTR[i];
				rdata_o[15:0] = 16'(ENT_ID[i]);
			end
			if (offset_i == addr_t'(2 * i + 1)) begin
				rdata_o = data_t'(ENT_MAPSZ[i]);
			end
		end
		if (offset_i == SOCID_WORD) begin
			rdata_o = data_t'(`SOC_SOC_ID);
		end
	end

	// One-cycle request toward the reset sequencer
	always_ff @(posedge clk48mhz) begin
		if (sys_rst_i) begin
			rst_req_o <= RST_REQ_NONE;
		end else if (ctrl_wr) begin
			rst_req_o <= rst_req_t'(wdata_i[1:0]);
		end else begin
			rst_req_o <= RST_REQ_NONE;
		end
	end

endmodule

// ==== hw/int_ctrl.sv ====
`timescale 1ns/1ps
`include "soc_defs.svh"

module int_ctrl
	import soc_pkg::*;
(
	input  logic     clk48mhz,
	input  logic     sys_rst_i,
	input  logic     stb_i,
	input  logic     we_i,
	input  addr_t    offset_i,
	input  data_t    wdata_i,
	output data_t    rdata_o,
	input  irq_vec_t irq_src_i,
	output irq_vec_t irq_ack_o,
	output logic     irq_o
);

	localparam addr_t CLAIM_WORD = addr_t'(0);
	localparam addr_t MASK_WORD  = addr_t'(1);

	irq_vec_t en_q;
	irq_vec_t pend;
	irq_vec_t claim_ack;
	data_t    claim_idx;
	logic     claim;
	logic     mask_wr;

	assign pend  = irq_src_i & en_q;
	assign irq_o = |pend;

	assign claim   = stb_i && !we_i && (offset_i == CLAIM_WORD);
	assign mask_wr = stb_i && we_i && (offset_i == MASK_WORD);

	// Lowest index wins, so scan from the top down
	always_comb begin
		claim_idx = '1;
		claim_ack = '0;
		for (int i = `SOC_IRQ_SRC_COUNT - 1; i >= 0; i--) begin
			if (pend[i]) begin
				claim_idx    = data_t'(i);
				claim_ack    = '0;
				claim_ack[i] = 1'b1;
			end
		end
	end

	always_comb begin
		rdata_o = '0;
		if (offset_i == CLAIM_WORD) begin
			rdata_o = claim_idx;
		end else if (offset_i == MASK_WORD) begin
			rdata_o[`SOC_IRQ_SRC_COUNT-1:0] = en_q;
		end
	end

	always_ff @(posedge clk48mhz) begin
		if (sys_rst_i) begin
			en_q <= '0;
		end else if (mask_wr) begin
			en_q <= wdata_i[`SOC_IRQ_SRC_COUNT-1:0];
		end
	end

	// Ack lines up with the bus ready of the claim read
	always_ff @(posedge clk48mhz) begin
		if (sys_rst_i) begin
			irq_ack_o <= '0;
		end else if (claim) begin
			irq_ack_o <= claim_ack;
		end else begin
			irq_ack_o <= '0;
		end
	end

endmodule

// ==== hw/soc_top.sv ====
`timescale 1ns/1ps

module soc_top
	import soc_pkg::*;
(
	input  logic     clk48mhz,
	input  logic     rst_p,
	input  bus_op_t  bus_op_i,
	input  addr_t    bus_addr_i,
	input  data_t    bus_wdata_i,
	output data_t    bus_rdata_o,
	output logic     bus_rdy_o,
	input  irq_vec_t irq_src_i,
	output irq_vec_t irq_ack_o,
	output logic     irq_o,
	output logic     sys_rst_o
);

	rst_req_t rst_req;
	logic     devtbl_stb;
	logic     intctrl_stb;
	logic     slv_we;
	addr_t    slv_offset;
	data_t    slv_wdata;
	data_t    devtbl_rdata;
	data_t    intctrl_rdata;

	reset_seq reset_seq_inst (
		.clk48mhz  (clk48mhz),
		.rst_p     (rst_p),
		.rst_req_i (rst_req),
		.sys_rst_o (sys_rst_o)
	);

	bus_decoder bus_decoder_inst (
		.clk48mhz        (clk48mhz),
		.sys_rst_i       (sys_rst_o),
		.bus_op_i        (bus_op_i),
		.bus_addr_i      (bus_addr_i),
		.bus_wdata_i     (bus_wdata_i),
		.bus_rdata_o     (bus_rdata_o),
		.bus_rdy_o       (bus_rdy_o),
		.devtbl_stb_o    (devtbl_stb),
		.intctrl_stb_o   (intctrl_stb),
		.slv_we_o        (slv_we),
		.slv_offset_o    (slv_offset),
		.slv_wdata_o     (slv_wdata),
		.devtbl_rdata_i  (devtbl_rdata),
		.intctrl_rdata_i (intctrl_rdata)
	);

	dev_table dev_table_inst (
		.clk48mhz  (clk48mhz),
		.sys_rst_i (sys_rst_o),
		.stb_i     (devtbl_stb),
		.we_i      (slv_we),
		.offset_i  (slv_offset),
		.wdata_i   (slv_wdata),
		.rdata_o   (devtbl_rdata),
		.rst_req_o (rst_req)
	);

	int_ctrl int_ctrl_inst (
		.clk48mhz  (clk48mhz),
		.sys_rst_i (sys_rst_o),
		.stb_i     (intctrl_stb),
		.we_i      (slv_we),
		.offset_i  (slv_offset),
		.wdata_i   (slv_wdata),
		.rdata_o   (intctrl_rdata),
		.irq_src_i (irq_src_i),
		.irq_ack_o (irq_ack_o),
		.irq_o     (irq_o)
	);

endmodule

// ==== bench/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
	output logic clk_o,
	output logic rst_o
);

	localparam int RST_LEN = 5;

	// 4 ns period
	initial begin
		clk_o = 1'b0;
		forever #2 clk_o = ~clk_o;
	end

	// Released shortly after the fifth rising edge
	initial begin
		rst_o = 1'b1;
		repeat (RST_LEN) @(posedge clk_o);
		#1 rst_o = 1'b0;
	end

endmodule

// ==== bench/soc_props.sv ====
`timescale 1ns/1ps

module soc_props
	import soc_pkg::*;
(
	input logic     clk48mhz,
	input logic     rst_p,
	input logic     rdy_i,
	input logic     sys_rst_i,
	input irq_vec_t irq_src_i,
	input irq_vec_t irq_ack_i
);

	int fail_cnt;

	initial begin
		fail_cnt = 0;
	end

	// Ready is a single-cycle pulse
	rdy_pulse: assert property (@(posedge clk48mhz) disable iff (rst_p)
		rdy_i |=> !rdy_i)
		else begin
			$error("bus_rdy_o high for two cycles in a row");
			fail_cnt++;
		end

	rdy_in_reset: assert property (@(posedge clk48mhz) disable iff (rst_p)
		sys_rst_i |-> !rdy_i)
		else begin
			$error("bus_rdy_o high while sys_rst_o is high");
			fail_cnt++;
		end

	ack_onehot: assert property (@(posedge clk48mhz) disable iff (rst_p)
		$onehot0(irq_ack_i))
		else begin
			$error("irq_ack_o has more than one bit set");
			fail_cnt++;
		end

	// Ack is registered, so compare against the sources at the claim edge
	ack_pending: assert property (@(posedge clk48mhz) disable iff (rst_p)
		(irq_ack_i & ~$past(irq_src_i)) == '0)
		else begin
			$error("irq_ack_o acknowledges a source that was not pending");
			fail_cnt++;
		end

endmodule

bind soc_top soc_props soc_props_inst (
	.clk48mhz  (clk48mhz),
	.rst_p     (rst_p),
	.rdy_i     (bus_rdy_o),
	.sys_rst_i (sys_rst_o),
	.irq_src_i (irq_src_i),
	.irq_ack_i (irq_ack_o)
);

// ==== bench/soc_tb.sv ====
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_tb
	import soc_pkg::*;
();

	localparam int DRV_DLY = 1;
	localparam int BUS_TIMEOUT = 32;
	localparam int RST_TIMEOUT = 8 * `SOC_RST_CYCLES;
	localparam addr_t CLAIM_ADDR = addr_t'(`SOC_INTCTRL_BASE);
	localparam addr_t MASK_ADDR = addr_t'(`SOC_INTCTRL_BASE + 1);
	localparam addr_t SOCID_ADDR = addr_t'(`SOC_DEVTBL_BASE + 14);
	localparam addr_t CTRL_ADDR = addr_t'(`SOC_DEVTBL_BASE + 15);

	logic     clk48mhz;
	logic     gen_rst;
	logic     tb_rst;
	logic     rst_p;
	bus_op_t  bus_op;
	addr_t    bus_addr;
	data_t    bus_wdata;
	data_t    bus_rdata;
	logic     bus_rdy;
	irq_vec_t irq_src;
	irq_vec_t irq_ack;
	logic     irq;
	logic     sys_rst;

	int          errors;
	int          tests_run;
	int          tests_failed;
	int          test_err_start;
	int          last_lat;
	irq_vec_t    last_ack;
	logic [31:0] rng_state;

	clk_gen clk_gen_inst (
		.clk_o (clk48mhz),
		.rst_o (gen_rst)
	);

	// Button reset is the power-on pulse or a pulse from a test
	assign rst_p = gen_rst || tb_rst;

	soc_top soc_top_inst (
		.clk48mhz    (clk48mhz),
		.rst_p       (rst_p),
		.bus_op_i    (bus_op),
		.bus_addr_i  (bus_addr),
		.bus_wdata_i (bus_wdata),
		.bus_rdata_o (bus_rdata),
		.bus_rdy_o   (bus_rdy),
		.irq_src_i   (irq_src),
		.irq_ack_o   (irq_ack),
		.irq_o       (irq),
		.sys_rst_o   (sys_rst)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic report_mismatch(input string sig, input data_t got, input data_t exp);
		$display("CHECK FAILED %s got %h expected %h at %0t", sig, got, exp, $time);
		errors++;
	endtask

	task automatic report_problem(input string what);
		$display("ERROR %s at %0t", what, $time);
		errors++;
	endtask

	task automatic begin_test();
		test_err_start = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_err_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d failed checks", name, errors - test_err_start);
		end
	endtask

	// Samples and drives happen just after the rising edge
	task automatic next_edge();
		@(posedge clk48mhz);
		#DRV_DLY;
	endtask

	task automatic bus_xfer(input bus_op_t op, input addr_t a, input data_t wd,
		output data_t rd);
		bit seen;
		next_edge();
		bus_op = op;
		bus_addr = a;
		bus_wdata = wd;
		seen = 1'b0;
		last_lat = 0;
		while (!seen && last_lat < BUS_TIMEOUT) begin
			next_edge();
			last_lat++;
			seen = (bus_rdy === 1'b1);
		end
		rd = bus_rdata;
		last_ack = irq_ack;
		bus_op = OP_NONE;
		if (!seen) begin
			report_problem($sformatf("no bus ready for address %h within %0d cycles",
				a, BUS_TIMEOUT));
		end
	endtask

	task automatic bus_write(input addr_t a, input data_t d);
		data_t unused;
		bus_xfer(OP_WRITE, a, d, unused);
	endtask

	task automatic bus_read(input addr_t a, output data_t d);
		bus_xfer(OP_READ, a, '0, d);
	endtask

	task automatic wait_sys_rst(input logic level, input string what);
		int n;
		n = 0;
		while (sys_rst !== level && n < RST_TIMEOUT) begin
			next_edge();
			n++;
		end
		if (sys_rst !== level) begin
			report_problem($sformatf("sys_rst_o never went to %0d while %s", level, what));
		end
	endtask

	// Starts on a sample where sys_rst_o is high and counts until it drops
	task automatic measure_rst_len(output int len);
		len = 0;
		do begin
			next_edge();
			len++;
			if (bus_rdy !== 1'b0) report_mismatch("bus_rdy_o", data_t'(bus_rdy), '0);
			if (irq !== 1'b0) report_mismatch("irq_o", data_t'(irq), '0);
		end while (sys_rst !== 1'b0 && len < RST_TIMEOUT);
		if (sys_rst !== 1'b0) report_problem("sys_rst_o stayed high past the timeout");
	endtask

	task automatic test_reset();
		int len;
		begin_test();
		bus_write(MASK_ADDR, 32'h3);
		next_edge();
		tb_rst = 1'b1;
		next_edge();
		// A waiting request and live sources must stay hidden during reset
		bus_op = OP_READ;
		bus_addr = SOCID_ADDR;
		irq_src = '1;
		repeat (2) next_edge();
		tb_rst = 1'b0;
		measure_rst_len(len);
		bus_op = OP_NONE;
		irq_src = '0;
		if (len != `SOC_RST_CYCLES) begin
			report_mismatch("sys_rst_o cycles", data_t'(len), data_t'(`SOC_RST_CYCLES));
		end
		end_test("reset");
	endtask

	task automatic test_dev_table();
		data_t rd;
		data_t exp;
		begin_test();
		for (int w = 0; w < `SOC_DEVTBL_WORDS; w++) begin
			// Id with interrupt flag clear, then map size in bytes
			case (w)
				0: exp = data_t'(`SOC_ID_DEVTBL);
				1: exp = data_t'(64);
				2: exp = data_t'(`SOC_ID_INTCTRL);
				3: exp = data_t'(16);
				4: exp = data_t'(`SOC_ID_INVALID);
				5: exp = data_t'(0);
				14: exp = data_t'(`SOC_SOC_ID);
				default: exp = '0;
			endcase
			bus_read(addr_t'(`SOC_DEVTBL_BASE + w), rd);
			if (rd !== exp) report_mismatch($sformatf("bus_rdata_o word %0d", w), rd, exp);
		end
		end_test("dev_table");
	endtask

	task automatic test_invalid();
		data_t rd;
		addr_t a;
		begin_test();
		repeat (8) begin
			rng_state = xorshift32(rng_state);
			a = addr_t'(32'd20 + (rng_state % 32'h3FFF_FFEC));
			bus_read(a, rd);
			if (rd !== '0) report_mismatch("bus_rdata_o", rd, '0);
			if (last_lat != 1) report_mismatch("bus_rdy_o latency", data_t'(last_lat), 1);
			bus_write(a, xorshift32(rng_state));
			bus_read(a, rd);
			if (rd !== '0) report_mismatch("bus_rdata_o after write", rd, '0);
		end
		end_test("invalid_device");
	endtask

	task automatic test_interrupts();
		data_t rd;
		data_t v;
		begin_test();
		for (int i = 0; i < 4; i++) begin
			v = data_t'((i + 1) % 4);
			bus_write(MASK_ADDR, v);
			bus_read(MASK_ADDR, rd);
			if (rd !== v) report_mismatch("enable mask", rd, v);
		end

		// Source 1 pending but only source 0 enabled
		bus_write(MASK_ADDR, 32'h1);
		irq_src = 2'b10;
		next_edge();
		next_edge();
		if (irq !== 1'b0) report_mismatch("irq_o", data_t'(irq), '0);

		irq_src = 2'b11;
		bus_write(MASK_ADDR, 32'h3);
		if (irq !== 1'b1) report_mismatch("irq_o", data_t'(irq), 1);

		// Lowest index is claimed first, the source drops on its ack
		bus_read(CLAIM_ADDR, rd);
		if (rd !== 32'd0) report_mismatch("claim index", rd, 0);
		if (last_ack !== 2'b01) report_mismatch("irq_ack_o", data_t'(last_ack), 1);
		irq_src[0] = 1'b0;
		bus_read(CLAIM_ADDR, rd);
		if (rd !== 32'd1) report_mismatch("claim index", rd, 1);
		if (last_ack !== 2'b10) report_mismatch("irq_ack_o", data_t'(last_ack), 2);
		irq_src[1] = 1'b0;
		next_edge();
		if (irq !== 1'b0) report_mismatch("irq_o", data_t'(irq), '0);
		if (irq_ack !== 2'b00) report_mismatch("irq_ack_o", data_t'(irq_ack), '0);

		bus_read(CLAIM_ADDR, rd);
		if (rd !== 32'hFFFF_FFFF) report_mismatch("claim index", rd, 32'hFFFF_FFFF);
		if (last_ack !== 2'b00) report_mismatch("irq_ack_o", data_t'(last_ack), '0);
		end_test("interrupts");
	endtask

	task automatic test_sw_reset();
		data_t rd;
		int len;
		int lows;
		begin_test();
		bus_write(MASK_ADDR, 32'h3);
		bus_write(CTRL_ADDR, data_t'(RST_REQ_WARM));
		wait_sys_rst(1'b1, "waiting for the warm reset");
		measure_rst_len(len);
		if (len != `SOC_RST_CYCLES) begin
			report_mismatch("sys_rst_o cycles", data_t'(len), data_t'(`SOC_RST_CYCLES));
		end
		bus_read(MASK_ADDR, rd);
		if (rd !== '0) report_mismatch("enable mask after reset", rd, '0);

		// Power-off holds until the button
		bus_write(CTRL_ADDR, data_t'(RST_REQ_POWEROFF));
		wait_sys_rst(1'b1, "waiting for power-off");
		lows = 0;
		repeat (4 * `SOC_RST_CYCLES) begin
			next_edge();
			if (sys_rst !== 1'b1) lows++;
		end
		if (lows != 0) report_mismatch("sys_rst_o low cycles", data_t'(lows), '0);
		tb_rst = 1'b1;
		repeat (2) next_edge();
		tb_rst = 1'b0;
		measure_rst_len(len);
		if (len != `SOC_RST_CYCLES) begin
			report_mismatch("sys_rst_o cycles", data_t'(len), data_t'(`SOC_RST_CYCLES));
		end
		bus_read(SOCID_ADDR, rd);
		if (rd !== data_t'(`SOC_SOC_ID)) report_mismatch("SoC id", rd, `SOC_SOC_ID);
		end_test("sw_reset");
	endtask

	initial begin
		bus_op = OP_NONE;
		bus_addr = '0;
		bus_wdata = '0;
		irq_src = '0;
		tb_rst = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_err_start = 0;
		last_lat = 0;
		last_ack = '0;
		rng_state = 32'h3aec;

		wait_sys_rst(1'b0, "waiting for the power-on reset to end");
		test_reset();
		test_dev_table();
		test_invalid();
		test_interrupts();
		test_sw_reset();

		if (soc_top_inst.soc_props_inst.fail_cnt != 0) begin
			report_problem($sformatf("%0d bound assertions failed",
				soc_top_inst.soc_props_inst.fail_cnt));
		end

		$display("%0d tests run, %0d tests failed, %0d checks failed",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+include
hw/soc_pkg.sv
hw/reset_seq.sv
hw/bus_decoder.sv
hw/dev_table.sv
hw/int_ctrl.sv
hw/soc_top.sv
bench/clk_gen.sv
bench/soc_props.sv
bench/soc_tb.sv

// ==== Bender.yml ====
package:
  name: soc_bus

sources:
  - include_dirs:
      - include
    files:
      - hw/soc_pkg.sv
      - hw/reset_seq.sv
      - hw/bus_decoder.sv
      - hw/dev_table.sv
      - hw/int_ctrl.sv
      - hw/soc_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/clk_gen.sv
      - bench/soc_props.sv
      - bench/soc_tb.sv
